// File: tests/load_unit_golden.txt
# S addr data mask | L rob op rd stq addr value | D rob op rd stq value | A rob addr
# F flush | I cycles | R ready | W wait and check (op: 0 LB 1 LH 2 LW 4 LBU 5 LHU)
R 1
S 00000010 8091a2f3 f
S 00000014 7f01ff40 f
L 01 0 21 0 00000010 fffffff3
L 02 0 22 0 00000011 ffffffa2
L 03 0 23 0 00000012 ffffff91
L 04 0 24 0 00000013 ffffff80
L 05 4 25 0 00000014 00000040
L 06 4 26 0 00000015 000000ff
L 07 4 27 0 00000016 00000001
L 08 4 28 0 00000017 0000007f
L 09 1 29 0 00000010 ffffa2f3
L 0a 1 2a 0 00000012 ffff8091
L 0b 5 2b 0 00000014 0000ff40
L 0c 5 2c 0 00000016 00007f01
L 0d 2 2d 0 00000010 8091a2f3
W
L 0e 2 30 2 00000020 12345678
I 3
S 00000020 12340000 c
S 00000020 00005678 3
W
D 0f 2 31 0 8091a2f3
D 10 4 32 0 000000ff
D 11 5 33 0 00001234
A 11 00000022
A 0f 00000010
A 10 00000015
W
L 12 2 34 1 00000030 cafe0180
L 13 0 35 1 00000031 00000001
L 14 1 36 1 00000032 ffffcafe
L 15 4 37 1 00000030 00000080
R 0
S 00000030 cafe0180 f
L 16 5 38 0 00000032 0000cafe
W
D 17 2 39 0 00000000
D 18 2 3a 0 00000000
A 17 00000010
I 1
F
I 4
L 19 2 3b 0 00000014 7f01ff40
W
L 1a 2 3c 0 00000014 7f01ff40
S 00000038 11111111 f
S 0000003c 22222222 f
S 00000040 33333333 f
L 1b 0 3d 0 00000038 00000011
W

// File: filelist.f
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_ifs.sv
logic/load_queue.sv
logic/data_ram.sv
logic/load_writeback.sv
logic/load_unit_top.sv
tests/load_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module load_unit_tb -o load_unit_sim

./obj_dir/load_unit_sim | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    exit 0
else
    exit 1
fi

// File: tests/load_unit_tb.sv
`include "lsu_settings.svh"

module load_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic               clk;
    logic               rst_n;
    logic               flush;
    logic               disp_valid;
    logic               disp_ready;
    lsu_pkg::rob_id_t   disp_rob_id;
    lsu_pkg::load_op_e  disp_op;
    lsu_pkg::phy_reg_t  disp_rd_phy;
    logic               agu_valid;
    lsu_pkg::rob_id_t   agu_rob_id;
    logic [31:0]        agu_addr;
    logic               st_commit;
    logic [31:0]        st_addr;
    logic [31:0]        st_data;
    logic [3:0]         st_wmask;
    lsu_pkg::stq_cnt_t  stq_count;
    logic               wb_valid;
    lsu_pkg::rob_id_t   wb_rob_id;
    lsu_pkg::phy_reg_t  wb_rd_phy;
    logic [31:0]        wb_value;

    // per rob id bookkeeping.
    bit                 pending   [32];
    bit                 got       [32];
    logic [31:0]        exp_value [32];
    logic [31:0]        exp_addr  [32];
    lsu_pkg::load_op_e  exp_op    [32];
    lsu_pkg::phy_reg_t  exp_rd    [32];
    logic [31:0]        got_value [32];
    lsu_pkg::phy_reg_t  got_rd    [32];
    logic [31:0]        ref_mem   [`DMEM_WORDS];
    int                 cycles;
    int                 limit;

    load_unit_top i_load_unit_top (.*);

    always #10 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            fail_now($sformatf("ERROR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_rob_id(input string name, input lsu_pkg::rob_id_t exp,
                                input lsu_pkg::rob_id_t act);
        if (exp !== act) begin
            fail_now($sformatf("ERROR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_rd_phy(input string name, input lsu_pkg::phy_reg_t exp,
                                input lsu_pkg::phy_reg_t act);
        if (exp !== act) begin
            fail_now($sformatf("ERROR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            fail_now($sformatf("ERROR %s expected %b actual %b", name, exp, act));
        end
    endtask

    // riscv load rule applied to the reference memory.
    function automatic logic [31:0] load_model(input lsu_pkg::load_op_e op, input logic [31:0] addr);
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        word = ref_mem[addr[7:2]];
        b    = word[8*addr[1:0] +: 8];
        h    = addr[1] ? word[31:16] : word[15:0];
        case (op)
            lsu_pkg::LB:  return 32'($signed(b));
            lsu_pkg::LBU: return 32'(b);
            lsu_pkg::LH:  return 32'($signed(h));
            lsu_pkg::LHU: return 32'(h);
            default:      return word;
        endcase
    endfunction

    // --------------------------------------------------
    // stimulus tasks, each entered on a falling edge
    // --------------------------------------------------
    task automatic store_commit(input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] mask);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                ref_mem[addr[7:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
        st_commit = 1'b1;
        st_addr   = addr;
        st_data   = data;
        st_wmask  = mask;
        @(negedge clk);
        st_commit = 1'b0;
    endtask

    task automatic dispatch(input logic [31:0] rob, input logic [31:0] op,
                            input logic [31:0] rd, input logic [31:0] cnt);
        disp_valid  = 1'b1;
        disp_rob_id = rob[4:0];
        disp_op     = lsu_pkg::load_op_e'(op[2:0]);
        disp_rd_phy = rd[5:0];
        stq_count   = cnt[3:0];
        while (!disp_ready) begin // queue full, hold the request.
            @(negedge clk);
        end
        @(negedge clk);
        disp_valid = 1'b0;
        stq_count  = '0;
    endtask

    task automatic agu_write(input logic [31:0] rob, input logic [31:0] addr);
        exp_addr[rob[4:0]] = addr;
        agu_valid  = 1'b1;
        agu_rob_id = rob[4:0];
        agu_addr   = addr;
        @(negedge clk);
        agu_valid = 1'b0;
    endtask

    task automatic expect_load(input logic [31:0] rob, input logic [31:0] op,
                               input logic [31:0] rd, input logic [31:0] value);
        pending[rob[4:0]]   = 1'b1;
        got[rob[4:0]]       = 1'b0;
        exp_op[rob[4:0]]    = lsu_pkg::load_op_e'(op[2:0]);
        exp_rd[rob[4:0]]    = rd[5:0];
        exp_value[rob[4:0]] = value;
    endtask

    task automatic wait_results(input string name);
        bit          all_in;
        logic [31:0] model;
        all_in = 1'b0;
        while (!all_in) begin
            all_in = 1'b1;
            for (int i = 0; i < 32; i++) begin
                if (pending[i] && !got[i]) begin
                    all_in = 1'b0;
                end
            end
            if (!all_in) begin
                @(negedge clk);
            end
        end
        for (int i = 0; i < 32; i++) begin
            if (pending[i]) begin
                model = load_model(exp_op[i], exp_addr[i]);
                check_value($sformatf("%s golden rob %0h", name, i), exp_value[i], model);
                check_value($sformatf("%s value rob %0h", name, i), model, got_value[i]);
                check_rd_phy($sformatf("%s rd_phy rob %0h", name, i), exp_rd[i], got_rd[i]);
                pending[i] = 1'b0;
                got[i]     = 1'b0;
            end
        end
    endtask

    task automatic run_record(input string line, input int idx);
        byte         cmd;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] f5;
        logic [31:0] f6;
        string       name;
        void'($sscanf(line, "%c %h %h %h %h %h %h", cmd, f1, f2, f3, f4, f5, f6));
        name = $sformatf("record %0d", idx);
        if (cmd == "L" || cmd == "D") begin
            repeat ($urandom % 3) @(negedge clk); // random gap before dispatch.
        end
        case (cmd)
            "S": store_commit(f1, f2, f3[3:0]);
            "L": begin
                expect_load(f1, f2, f3, f6);
                dispatch(f1, f2, f3, f4);
                agu_write(f1, f5);
            end
            "D": begin
                expect_load(f1, f2, f3, f5);
                dispatch(f1, f2, f3, f4);
            end
            "A": agu_write(f1, f2);
            "F": begin
                flush = 1'b1;
                for (int i = 0; i < 32; i++) begin
                    pending[i] = 1'b0;
                end
                @(negedge clk);
                flush = 1'b0;
            end
            "I": repeat (f1) @(negedge clk);
            "R": begin
                check_ready(name, f1[0], disp_ready);
                @(negedge clk);
            end
            "W": wait_results(name);
            default: fail_now($sformatf("golden file has an unknown record: %s", line));
        endcase
    endtask

    // --------------------------------------------------
    // result monitor and timeout
    // --------------------------------------------------
    always @(posedge clk) begin
        int owner;
        if (rst_n && wb_valid) begin
            owner = -1;
            for (int i = 0; i < 32; i++) begin // pending load that owns this rd_phy.
                if (pending[i] && !got[i] && exp_rd[i] == wb_rd_phy) begin
                    owner = i;
                end
            end
            if (!pending[wb_rob_id]) begin
                fail_now($sformatf("result for rob %0h arrived but none was expected", wb_rob_id));
            end else if (got[wb_rob_id]) begin
                fail_now($sformatf("rob %0h returned a result twice", wb_rob_id));
            end else begin
                if (owner >= 0) begin
                    check_rob_id($sformatf("rob_id for rd_phy %0h", wb_rd_phy),
                                 lsu_pkg::rob_id_t'(owner), wb_rob_id);
                end
                got[wb_rob_id]       = 1'b1;
                got_value[wb_rob_id] = wb_value;
                got_rd[wb_rob_id]    = wb_rd_phy;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit != 0 && cycles >= limit) begin
            fail_now("timeout: load results never arrived");
        end
    end

    initial begin
        string lines[$];
        string line;
        int    fd;
        int    outstanding;
        void'($urandom(83));
        clk = 1'b0;
        rst_n = 1'b0;
        flush = 1'b0;
        disp_valid = 1'b0;
        disp_rob_id = '0;
        disp_op = lsu_pkg::LW;
        disp_rd_phy = '0;
        agu_valid = 1'b0;
        agu_rob_id = '0;
        agu_addr = '0;
        st_commit = 1'b0;
        st_addr = '0;
        st_data = '0;
        st_wmask = '0;
        stq_count = '0;
        cycles = 0;
        limit = 0;
        for (int w = 0; w < `DMEM_WORDS; w++) begin
            ref_mem[w] = '0;
        end
        fd = $fopen("tests/load_unit_golden.txt", "r");
        if (fd == 0) begin
            fail_now("golden file tests/load_unit_golden.txt could not be opened");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                lines.push_back(line);
            end
        end
        $fclose(fd);
        limit = 20 * lines.size();

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (lines[i]) begin
            run_record(lines[i], i);
        end

        outstanding = 0;
        for (int i = 0; i < 32; i++) begin
            if (pending[i]) begin
                outstanding++;
            end
        end
        if (outstanding == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            fail_now("loads were still outstanding at the end of the golden file");
        end
    end

endmodule

// File: logic/load_unit_top.sv
module load_unit_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,

    input  logic               disp_valid,
    output logic               disp_ready,
    input  lsu_pkg::rob_id_t   disp_rob_id,
    input  lsu_pkg::load_op_e  disp_op,
    input  lsu_pkg::phy_reg_t  disp_rd_phy,

    input  logic               agu_valid,
    input  lsu_pkg::rob_id_t   agu_rob_id,
    input  logic [31:0]        agu_addr,

    input  logic               st_commit,
    input  logic [31:0]        st_addr,
    input  logic [31:0]        st_data,
    input  logic [3:0]         st_wmask,
    input  lsu_pkg::stq_cnt_t  stq_count,

    output logic               wb_valid,
    output lsu_pkg::rob_id_t   wb_rob_id,
    output lsu_pkg::phy_reg_t  wb_rd_phy,
    output logic [31:0]        wb_value
);
    ldq_dmem_if dmem_if ();
    ldq_wb_if   wb_if ();

    load_queue i_load_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .disp_valid  (disp_valid),
        .disp_ready  (disp_ready),
        .disp_rob_id (disp_rob_id),
        .disp_op     (disp_op),
        .disp_rd_phy (disp_rd_phy),
        .agu_valid   (agu_valid),
        .agu_rob_id  (agu_rob_id),
        .agu_addr    (agu_addr),
        .st_commit   (st_commit),
        .stq_count   (stq_count),
        .dmem        (dmem_if.queue),
        .wb          (wb_if.queue)
    );

    data_ram i_data_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .st_commit (st_commit),
        .st_addr   (st_addr),
        .st_data   (st_data),
        .st_wmask  (st_wmask),
        .flush     (flush),
        .dmem      (dmem_if.ram)
    );

    load_writeback i_load_writeback (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb        (wb_if.wb),
        .dmem      (dmem_if.wb),
        .wb_valid  (wb_valid),
        .wb_rob_id (wb_rob_id),
        .wb_rd_phy (wb_rd_phy),
        .wb_value  (wb_value)
    );

endmodule

// File: logic/load_writeback.sv
module load_writeback (
    input  logic               clk,
    input  logic               rst_n,
    ldq_wb_if.wb               wb,
    ldq_dmem_if.wb             dmem,
    output logic               wb_valid,
    output lsu_pkg::rob_id_t   wb_rob_id,
    output lsu_pkg::phy_reg_t  wb_rd_phy,
    output logic [31:0]        wb_value
);
    logic              in_flight;
    lsu_pkg::rob_id_t  tag_rob_id;
    lsu_pkg::phy_reg_t tag_rd_phy;
    lsu_pkg::load_op_e tag_op;
    logic [1:0]        tag_offset;
    logic [7:0]        sel_byte;
    logic [15:0]       sel_half;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight <= 1'b0;
        end else begin
            in_flight <= wb.fire;
        end
    end

    always_ff @(posedge clk) begin
        if (wb.fire) begin
            tag_rob_id <= wb.rob_id;
            tag_rd_phy <= wb.rd_phy;
            tag_op     <= wb.op;
            tag_offset <= wb.offset;
        end
    end

    // --------------------------------------------------
    // lane select and extension
    // --------------------------------------------------
    assign sel_byte = dmem.rdata[{tag_offset, 3'b000} +: 8];
    assign sel_half = dmem.rdata[{tag_offset[1], 4'b0000} +: 16];

    always_comb begin
        unique case (tag_op)
            lsu_pkg::LB:  wb_value = {{24{sel_byte[7]}}, sel_byte};
            lsu_pkg::LBU: wb_value = {24'd0, sel_byte};
            lsu_pkg::LH:  wb_value = {{16{sel_half[15]}}, sel_half};
            lsu_pkg::LHU: wb_value = {16'd0, sel_half};
            default:      wb_value = dmem.rdata; // lw.
        endcase
    end

    assign wb_valid  = dmem.resp && in_flight;
    assign wb_rob_id = tag_rob_id;
    assign wb_rd_phy = tag_rd_phy;

endmodule

// File: logic/data_ram.sv
`include "lsu_settings.svh"

module data_ram (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        st_commit,
    input  logic [31:0] st_addr,
    input  logic [31:0] st_data,
    input  logic [3:0]  st_wmask,
    input  logic        flush,
    ldq_dmem_if.ram     dmem
);
    localparam int IDX_W = $clog2(`DMEM_WORDS);

    logic [31:0]      mem [`DMEM_WORDS];
    logic [IDX_W-1:0] st_idx;
    logic [IDX_W-1:0] rd_idx;
    logic [31:0]      lane_mask;
    logic             accept;
    logic             resp_q;
    logic [31:0]      rdata_q;

    assign st_idx = st_addr[IDX_W+1:2];
    assign rd_idx = dmem.addr[IDX_W+1:2];

    // a committing store owns the port.
    assign dmem.ready = !st_commit;
    assign accept     = dmem.valid && dmem.ready;
    assign lane_mask  = {{8{dmem.rmask[3]}}, {8{dmem.rmask[2]}},
                         {8{dmem.rmask[1]}}, {8{dmem.rmask[0]}}};

    // --------------------------------------------------
    // storage
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < `DMEM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (st_commit) begin
            for (int b = 0; b < 4; b++) begin
                if (st_wmask[b]) begin
                    mem[st_idx][8*b +: 8] <= st_data[8*b +: 8];
                end
            end
        end
    end

    // --------------------------------------------------
    // read response
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_q <= 1'b0;
        end else begin
            resp_q <= accept && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= mem[rd_idx] & lane_mask; // unused lanes read as zero.
        end
    end

    assign dmem.resp  = resp_q && !flush; // flush kills a response in flight.
    assign dmem.rdata = rdata_q;

    // an address past the last word would alias a lower one.
    a_addr_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(dmem.valid && dmem.addr[31:IDX_W+2] != '0) &&
        !(st_commit && st_addr[31:IDX_W+2] != '0)
    );

endmodule

// File: logic/load_queue.sv
`include "lsu_settings.svh"

module load_queue (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               disp_valid,
    output logic               disp_ready,
    input  lsu_pkg::rob_id_t   disp_rob_id,
    input  lsu_pkg::load_op_e  disp_op,
    input  lsu_pkg::phy_reg_t  disp_rd_phy,
    input  logic               agu_valid,
    input  lsu_pkg::rob_id_t   agu_rob_id,
    input  logic [31:0]        agu_addr,
    input  logic               st_commit,
    input  lsu_pkg::stq_cnt_t  stq_count,
    ldq_dmem_if.queue          dmem,
    ldq_wb_if.queue            wb
);
    localparam int IDX_W = $clog2(`LDQ_DEPTH);

    lsu_pkg::ldq_entry_t q     [`LDQ_DEPTH];
    lsu_pkg::ldq_entry_t q_nxt [`LDQ_DEPTH];

    logic             push_en;
    logic [IDX_W-1:0] push_idx;
    logic             has_free;
    logic             issue_en;
    logic [IDX_W-1:0] issue_idx;
    logic             accept;
    logic [3:0]       issue_mask;
    logic             agu_hit;
    logic             dup_rob;

    // --------------------------------------------------
    // allocation
    // --------------------------------------------------
    always_comb begin
        has_free = 1'b0;
        push_idx = '0;
        for (int i = `LDQ_DEPTH - 1; i >= 0; i--) begin // lowest free wins.
            if (!q[i].valid) begin
                has_free = 1'b1;
                push_idx = IDX_W'(i);
            end
        end
    end

    assign disp_ready = has_free;
    assign push_en    = disp_valid && has_free;

    // --------------------------------------------------
    // next state of the entries
    // --------------------------------------------------
    always_comb begin
        agu_hit = 1'b0;
        for (int i = 0; i < `LDQ_DEPTH; i++) begin
            q_nxt[i] = q[i];
            if (q[i].valid && st_commit && q[i].stores_ahead != '0) begin
                q_nxt[i].stores_ahead = q[i].stores_ahead - lsu_pkg::stq_cnt_t'(1);
            end
            if (agu_valid && q[i].valid && q[i].rob_id == agu_rob_id) begin
                agu_hit             = 1'b1;
                q_nxt[i].addr_valid = 1'b1;
                q_nxt[i].addr       = agu_addr;
            end
        end

        if (push_en) begin
            q_nxt[push_idx].valid      = 1'b1;
            q_nxt[push_idx].addr_valid = 1'b0;
            q_nxt[push_idx].rob_id     = disp_rob_id;
            q_nxt[push_idx].op         = disp_op;
            q_nxt[push_idx].rd_phy     = disp_rd_phy;
            // the committing store is no longer ahead.
            if (st_commit && stq_count != '0) begin
                q_nxt[push_idx].stores_ahead = stq_count - lsu_pkg::stq_cnt_t'(1);
            end else begin
                q_nxt[push_idx].stores_ahead = stq_count;
            end
        end

        if (accept) begin
            q_nxt[issue_idx].valid = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `LDQ_DEPTH; i++) begin
                q[i].valid      <= 1'b0;
                q[i].addr_valid <= 1'b0;
            end
        end else if (flush) begin
            for (int i = 0; i < `LDQ_DEPTH; i++) begin
                q[i].valid      <= 1'b0;
                q[i].addr_valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `LDQ_DEPTH; i++) begin
                q[i] <= q_nxt[i];
            end
        end
    end

    // --------------------------------------------------
    // issue select
    // --------------------------------------------------
    always_comb begin
        issue_en  = 1'b0;
        issue_idx = '0;
        for (int i = `LDQ_DEPTH - 1; i >= 0; i--) begin
            if (q[i].valid && q[i].addr_valid && q[i].stores_ahead == '0) begin
                issue_en  = 1'b1;
                issue_idx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        unique case (q[issue_idx].op)
            lsu_pkg::LB, lsu_pkg::LBU: issue_mask = 4'b0001 << q[issue_idx].addr[1:0];
            lsu_pkg::LH, lsu_pkg::LHU: issue_mask = 4'b0011 << {q[issue_idx].addr[1], 1'b0};
            default:                   issue_mask = 4'b1111;
        endcase
    end

    assign dmem.valid = issue_en && !flush;
    assign dmem.addr  = {q[issue_idx].addr[31:2], 2'b00};
    assign dmem.rmask = issue_mask;
    assign accept     = dmem.valid && dmem.ready;

    assign wb.fire   = accept;
    assign wb.rob_id = q[issue_idx].rob_id;
    assign wb.rd_phy = q[issue_idx].rd_phy;
    assign wb.op     = q[issue_idx].op;
    assign wb.offset = q[issue_idx].addr[1:0];

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    always_comb begin
        dup_rob = 1'b0;
        for (int i = 0; i < `LDQ_DEPTH; i++) begin
            for (int j = i + 1; j < `LDQ_DEPTH; j++) begin
                if (q[i].valid && q[j].valid && q[i].rob_id == q[j].rob_id) begin
                    dup_rob = 1'b1;
                end
            end
        end
    end

    a_unique_rob_id: assert property (@(posedge clk) disable iff (!rst_n) !dup_rob);

    // address only arrives for a load already queued.
    a_agu_hits_entry: assert property (
        @(posedge clk) disable iff (!rst_n || flush) agu_valid |-> agu_hit
    );

endmodule

// File: logic/lsu_ifs.sv
// --------------------------------------------------
// load queue to data memory port
// --------------------------------------------------
interface ldq_dmem_if;
    logic        valid;
    logic        ready;
    logic [31:0] addr;  // word aligned.
    logic [3:0]  rmask;
    logic        resp;  // one cycle after acceptance.
    logic [31:0] rdata;

    modport queue (
        output valid,
        output addr,
        output rmask,
        input  ready
    );

    modport ram (
        input  valid,
        input  addr,
        input  rmask,
        output ready,
        output resp,
        output rdata
    );

    // writeback only sees the returning data.
    modport wb (
        input  resp,
        input  rdata
    );
endinterface

// --------------------------------------------------
// tags of the load being issued
// --------------------------------------------------
interface ldq_wb_if;
    logic              fire; // request accepted by memory.
    lsu_pkg::rob_id_t  rob_id;
    lsu_pkg::phy_reg_t rd_phy;
    lsu_pkg::load_op_e op;
    logic [1:0]        offset;

    modport queue (
        output fire,
        output rob_id,
        output rd_phy,
        output op,
        output offset
    );

    modport wb (
        input  fire,
        input  rob_id,
        input  rd_phy,
        input  op,
        input  offset
    );
endinterface

// File: logic/lsu_pkg.sv
`include "lsu_settings.svh"

package lsu_pkg;

    // --------------------------------------------------
    // load opcodes, encoded as the riscv funct3 field
    // --------------------------------------------------
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_op_e;

    // --------------------------------------------------
    // tags and counters
    // --------------------------------------------------
    typedef logic [`ROB_ID_W-1:0]  rob_id_t;
    typedef logic [`PHY_REG_W-1:0] phy_reg_t;

    // must hold 0 up to STQ_DEPTH inclusive.
    typedef logic [$clog2(`STQ_DEPTH + 1)-1:0] stq_cnt_t;

    // --------------------------------------------------
    // load queue entry
    // --------------------------------------------------
    typedef struct packed {
        logic        valid;
        logic        addr_valid;   // agu has delivered the address.
        stq_cnt_t    stores_ahead; // older stores still to commit.
        rob_id_t     rob_id;
        load_op_e    op;
        phy_reg_t    rd_phy;
        logic [31:0] addr;
    } ldq_entry_t;

endpackage

// File: logic/lsu_settings.svh
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// --------------------------------------------------
// load queue and tag sizes
// --------------------------------------------------
`define LDQ_DEPTH   4
`define ROB_ID_W    5
`define PHY_REG_W   6

// store queue capacity, sets the stores-ahead counter width.
`define STQ_DEPTH   8

// --------------------------------------------------
// data memory
// --------------------------------------------------
`define DMEM_WORDS  64 // 32-bit words.

`endif
